// ==== logic/rv_isa_pkg.sv ====
////////////////////
// rv isa package
// instruction encodings, field widths and the ALU operation set
////////////////////

package rv_isa_pkg;

    // instruction word and field widths
    localparam int instr_w    = 32;
    localparam int opcode_w   = 7;
    localparam int reg_addr_w = 5;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int imm_i_w    = 12;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes handled by the pipeline
    typedef enum logic [opcode_w-1:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_other = 7'b0000000
    } opcode_e;

    // funct3 groups shared by the register and immediate forms
    typedef enum logic [funct3_w-1:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

    // funct7 of the register form, alt selects sub and sra
    localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

endpackage

// ==== logic/rv_pipe_pkg.sv ====
////////////////////
// rv pipe package
// structs handed from one pipeline stage to the next
////////////////////

package rv_pipe_pkg;

    // widest datapath, stages use the low xlen bits
    localparam int max_xlen = 64;

    // decode to operand read
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::alu_op_e   op;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        logic                  use_imm;
        logic [max_xlen-1:0]   imm;
        logic                  wr_en;
    } uop_t;

    // operand read to execute
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::alu_op_e   op;
        rv_isa_pkg::reg_addr_t rd;
        logic                  wr_en;
        logic [max_xlen-1:0]   a;
        logic [max_xlen-1:0]   b;
    } opnd_t;

    // execute to writeback, also used for the bypass
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t rd;
        logic                  wr_en;
        logic [max_xlen-1:0]   data;
    } wb_t;

endpackage

// ==== logic/rv_decode.sv ====
////////////////////
// rv decode
// first stage, instruction word to a registered micro-op
////////////////////

`timescale 1ns/100ps

module rv_decode #(
    parameter int xlen  = 32,
    parameter int rv32e = 0
) (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           srst,
    input  logic                           instr_valid,
    input  logic [rv_isa_pkg::instr_w-1:0] instr,
    output rv_pipe_pkg::uop_t              uop
);

    localparam int shw = $clog2(xlen);

    rv_isa_pkg::opcode_e             opcode;
    rv_isa_pkg::funct3_e             funct3;
    logic [rv_isa_pkg::funct7_w-1:0] funct7;
    rv_isa_pkg::reg_addr_t           rd;
    rv_isa_pkg::reg_addr_t           rs1;
    rv_isa_pkg::reg_addr_t           rs2;
    logic [rv_isa_pkg::imm_i_w-1:0]  imm12;
    logic [rv_isa_pkg::imm_i_w-1:0]  sh_rest;
    logic [xlen-1:0]                 imm_x;
    logic                            is_reg;
    logic                            is_imm;
    logic                            reg_ok;
    logic                            imm_ok;
    logic                            legal;
    logic                            e_bad;
    rv_isa_pkg::alu_op_e             op_d;
    rv_pipe_pkg::uop_t               uop_d;

    // instruction fields
    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = rv_isa_pkg::funct3_e'(instr[14:12]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm12  = instr[31:20];

    assign is_reg = (opcode == rv_isa_pkg::op_reg);
    assign is_imm = (opcode == rv_isa_pkg::op_imm);

    assign imm_x = {{(xlen-rv_isa_pkg::imm_i_w){imm12[rv_isa_pkg::imm_i_w-1]}}, imm12};

    // immediate bits above shamt, bit 30 masked out
    assign sh_rest = (imm12 & 12'hbff) >> shw;

    ////////////////////
    // legality
    ////////////////////

    assign reg_ok = (funct7 == rv_isa_pkg::f7_base) ||
                    ((funct7 == rv_isa_pkg::f7_alt) &&
                     ((funct3 == rv_isa_pkg::f3_add_sub) ||
                      (funct3 == rv_isa_pkg::f3_srl_sra)));

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_sll:     imm_ok = (sh_rest == '0) && !imm12[10];
            rv_isa_pkg::f3_srl_sra: imm_ok = (sh_rest == '0);
            default:                imm_ok = 1'b1;
        endcase
    end

    assign legal = (is_reg && reg_ok) || (is_imm && imm_ok);

    // rv32e has no x16..x31
    assign e_bad = (rv32e != 0) && (rd[4] || rs1[4] || (is_reg && rs2[4]));

    ////////////////////
    // operation select
    ////////////////////

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_add_sub: op_d = (is_reg && funct7[5]) ? rv_isa_pkg::alu_sub
                                                                 : rv_isa_pkg::alu_add;
            rv_isa_pkg::f3_sll:     op_d = rv_isa_pkg::alu_sll;
            rv_isa_pkg::f3_slt:     op_d = rv_isa_pkg::alu_slt;
            rv_isa_pkg::f3_sltu:    op_d = rv_isa_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:     op_d = rv_isa_pkg::alu_xor;
            rv_isa_pkg::f3_srl_sra: op_d = funct7[5] ? rv_isa_pkg::alu_sra
                                                     : rv_isa_pkg::alu_srl;
            rv_isa_pkg::f3_or:      op_d = rv_isa_pkg::alu_or;
            default:                op_d = rv_isa_pkg::alu_and;
        endcase
    end

    always_comb begin
        uop_d               = '0;
        uop_d.valid         = instr_valid;
        uop_d.op            = op_d;
        uop_d.rs1           = rs1;
        // immediate form has no second source
        uop_d.rs2           = is_reg ? rs2 : '0;
        uop_d.rd            = rd;
        uop_d.use_imm       = is_imm;
        uop_d.imm[xlen-1:0] = imm_x;
        uop_d.wr_en         = instr_valid && legal && (rd != '0) && !e_bad;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            uop <= '0;
        end else if (srst) begin
            uop <= '0;
        end else begin
            uop <= uop_d;
        end
    end

endmodule

// ==== logic/rv_regfile.sv ====
////////////////////
// rv regfile
// architectural registers, operand read with bypass, debug read
////////////////////

`timescale 1ns/100ps

module rv_regfile #(
    parameter int xlen  = 32,
    parameter int rv32e = 0
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  rv_pipe_pkg::uop_t     uop,
    input  rv_pipe_pkg::wb_t      ex_fwd,
    input  rv_pipe_pkg::wb_t      ex_wb,
    input  logic                  host_wr,
    input  rv_isa_pkg::reg_addr_t host_addr,
    input  logic [xlen-1:0]       host_val,
    input  rv_isa_pkg::reg_addr_t dbg_addr,
    output logic [xlen-1:0]       dbg_val,
    output rv_pipe_pkg::opnd_t    opnd
);

    localparam int nregs = (rv32e != 0) ? 16 : 32;
    localparam int idx_w = $clog2(nregs);

    logic [xlen-1:0]    regs [nregs];
    logic               wb_we;
    logic [xlen-1:0]    rs1_rf;
    logic [xlen-1:0]    rs2_rf;
    logic [xlen-1:0]    rs1_val;
    logic [xlen-1:0]    rs2_val;
    rv_pipe_pkg::opnd_t opnd_d;

    // youngest matching producer wins, x0 is always zero
    function automatic logic [xlen-1:0] resolve(
        input rv_isa_pkg::reg_addr_t src,
        input rv_pipe_pkg::wb_t      fwd,
        input rv_pipe_pkg::wb_t      wb,
        input logic [xlen-1:0]       rf_val
    );
        logic [xlen-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (fwd.valid && fwd.wr_en && (fwd.rd == src)) begin
            val = fwd.data[xlen-1:0];
        end else if (wb.valid && wb.wr_en && (wb.rd == src)) begin
            val = wb.data[xlen-1:0];
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    ////////////////////
    // register write
    ////////////////////

    assign wb_we = ex_wb.valid && ex_wb.wr_en;

    // x0 is only ever loaded by reset, indices past nregs never match
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (srst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < nregs; i++) begin
                if (wb_we && (ex_wb.rd == rv_isa_pkg::reg_addr_t'(i))) begin
                    regs[i] <= ex_wb.data[xlen-1:0];
                end else if (host_wr && (host_addr == rv_isa_pkg::reg_addr_t'(i))) begin
                    regs[i] <= host_val;
                end
            end
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    assign rs1_rf  = (int'(uop.rs1) < nregs) ? regs[uop.rs1[idx_w-1:0]] : '0;
    assign rs2_rf  = (int'(uop.rs2) < nregs) ? regs[uop.rs2[idx_w-1:0]] : '0;
    assign dbg_val = (int'(dbg_addr) < nregs) ? regs[dbg_addr[idx_w-1:0]] : '0;

    assign rs1_val = resolve(uop.rs1, ex_fwd, ex_wb, rs1_rf);
    assign rs2_val = resolve(uop.rs2, ex_fwd, ex_wb, rs2_rf);

    always_comb begin
        opnd_d             = '0;
        opnd_d.valid       = uop.valid;
        opnd_d.op          = uop.op;
        opnd_d.rd          = uop.rd;
        opnd_d.wr_en       = uop.wr_en;
        opnd_d.a[xlen-1:0] = rs1_val;
        opnd_d.b[xlen-1:0] = uop.use_imm ? uop.imm[xlen-1:0] : rs2_val;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            opnd <= '0;
        end else if (srst) begin
            opnd <= '0;
        end else begin
            opnd <= opnd_d;
        end
    end

endmodule

// ==== logic/rv_alu.sv ====
////////////////////
// rv alu
// execute stage, result and registered writeback
////////////////////

`timescale 1ns/100ps

module rv_alu #(
    parameter int xlen = 32
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    input  rv_pipe_pkg::opnd_t opnd,
    output rv_pipe_pkg::wb_t   ex_fwd,
    output rv_pipe_pkg::wb_t   ex_wb
);

    localparam int shw = $clog2(xlen);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [shw-1:0]  shamt;
    logic [xlen-1:0] result;

    assign a     = opnd.a[xlen-1:0];
    assign b     = opnd.b[xlen-1:0];
    // only the low log2(xlen) bits shift
    assign shamt = b[shw-1:0];

    always_comb begin
        case (opnd.op)
            rv_isa_pkg::alu_add:  result = a + b;
            rv_isa_pkg::alu_sub:  result = a - b;
            rv_isa_pkg::alu_and:  result = a & b;
            rv_isa_pkg::alu_or:   result = a | b;
            rv_isa_pkg::alu_xor:  result = a ^ b;
            rv_isa_pkg::alu_slt:  result = xlen'($signed(a) < $signed(b));
            rv_isa_pkg::alu_sltu: result = xlen'(a < b);
            rv_isa_pkg::alu_sll:  result = a << shamt;
            rv_isa_pkg::alu_srl:  result = a >> shamt;
            rv_isa_pkg::alu_sra:  result = $signed(a) >>> shamt;
            default:              result = a + b;
        endcase
    end

    ////////////////////
    // forward and writeback
    ////////////////////

    // value that enters ex_wb at the next edge
    always_comb begin
        ex_fwd                = '0;
        ex_fwd.valid          = opnd.valid;
        ex_fwd.rd             = opnd.rd;
        ex_fwd.wr_en          = opnd.wr_en;
        ex_fwd.data[xlen-1:0] = result;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ex_wb <= '0;
        end else if (srst) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_fwd;
        end
    end

endmodule

// ==== logic/rv_exec_top.sv ====
////////////////////
// rv exec top
// three stage integer pipeline around the register file
////////////////////

`timescale 1ns/100ps

module rv_exec_top #(
    parameter int xlen  = 32,
    parameter int rv32e = 0
) (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           srst,
    input  logic                           instr_valid,
    input  logic [rv_isa_pkg::instr_w-1:0] instr,
    input  logic                           host_wr,
    input  rv_isa_pkg::reg_addr_t          host_addr,
    input  logic [xlen-1:0]                host_val,
    input  rv_isa_pkg::reg_addr_t          dbg_addr,
    output logic [xlen-1:0]                dbg_val,
    output logic                           retire_valid,
    output logic                           retire_wr,
    output rv_isa_pkg::reg_addr_t          retire_rd,
    output logic [xlen-1:0]                retire_val
);

    rv_pipe_pkg::uop_t  dec_uop;
    rv_pipe_pkg::opnd_t rd_opnd;
    rv_pipe_pkg::wb_t   ex_fwd;
    rv_pipe_pkg::wb_t   ex_wb;

    rv_decode #(
        .xlen  (xlen),
        .rv32e (rv32e)
    ) decode_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .uop         (dec_uop)
    );

    rv_regfile #(
        .xlen  (xlen),
        .rv32e (rv32e)
    ) regfile_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .srst      (srst),
        .uop       (dec_uop),
        .ex_fwd    (ex_fwd),
        .ex_wb     (ex_wb),
        .host_wr   (host_wr),
        .host_addr (host_addr),
        .host_val  (host_val),
        .dbg_addr  (dbg_addr),
        .dbg_val   (dbg_val),
        .opnd      (rd_opnd)
    );

    rv_alu #(
        .xlen (xlen)
    ) alu_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .opnd    (rd_opnd),
        .ex_fwd  (ex_fwd),
        .ex_wb   (ex_wb)
    );

    // retire pulse straight from the writeback register
    assign retire_valid = ex_wb.valid;
    assign retire_wr    = ex_wb.wr_en;
    assign retire_rd    = ex_wb.rd;
    assign retire_val   = ex_wb.data[xlen-1:0];

endmodule

// ==== tb/rv_exec_monitor.sv ====
////////////////////
// rv exec monitor
// compares retirements and debug reads with expected values
////////////////////

`timescale 1ns/100ps

module rv_exec_monitor #(
    parameter int xlen = 32
) (
    input logic                  aclk,
    input logic                  aresetn,
    input logic                  retire_valid,
    input logic                  retire_wr,
    input rv_isa_pkg::reg_addr_t retire_rd,
    input logic [xlen-1:0]       retire_val,
    input logic [xlen-1:0]       dbg_val
);

    typedef struct packed {
        logic                  wr;
        rv_isa_pkg::reg_addr_t rd;
        logic [xlen-1:0]       val;
    } retire_t;

    retire_t exp_q[$];
    int      retire_errs = 0;
    int      dbg_errs = 0;

    task automatic push(input logic wr, input rv_isa_pkg::reg_addr_t rd,
                        input logic [xlen-1:0] val);
        exp_q.push_back('{wr: wr, rd: rd, val: val});
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // entries of instructions killed by srst
    task automatic flush();
        exp_q.delete();
    endtask

    task automatic check_dbg(input rv_isa_pkg::reg_addr_t addr, input logic [xlen-1:0] exp);
        if (dbg_val !== exp) begin
            $display("Error: %0t ns debug read x%0d gave %h, expected %h",
                     $time, addr, dbg_val, exp);
            dbg_errs++;
        end
    endtask

    // registered outputs have settled by the falling edge
    always @(negedge aclk) begin
        retire_t e;
        if (aresetn && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error: %0t ns retirement of x%0d with nothing expected",
                         $time, retire_rd);
                retire_errs++;
            end else begin
                e = exp_q.pop_front();
                if (retire_wr !== e.wr || retire_rd !== e.rd ||
                    (e.wr && retire_val !== e.val)) begin
                    $display("Error: %0t ns retire got wr%0b x%0d %h, expected wr%0b x%0d %h",
                             $time, retire_wr, retire_rd, retire_val, e.wr, e.rd, e.val);
                    retire_errs++;
                end
            end
        end
    end

endmodule

// ==== tb/rv_exec_checker.sv ====
////////////////////
// rv exec checker
// retire timing and x0 rules as concurrent assertions
////////////////////

`timescale 1ns/100ps

module rv_exec_checker (
    input logic                  aclk,
    input logic                  aresetn,
    input logic                  srst,
    input logic                  instr_valid,
    input logic                  retire_valid,
    input logic                  retire_wr,
    input rv_isa_pkg::reg_addr_t retire_rd
);

    // failed assertion count
    int fail_cnt = 0;

    // nothing retires while reset is held
    a_reset_quiet: assert property (@(posedge aclk) !aresetn |-> !retire_valid)
        else begin
            $error("retire_valid high during reset");
            fail_cnt++;
        end

    // fixed latency of three edges
    // srst drops the instructions in flight
    a_latency_fwd: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        instr_valid |-> ##3 retire_valid)
        else begin
            $error("instruction did not retire three cycles later");
            fail_cnt++;
        end

    a_latency_rev: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        retire_valid |-> $past(instr_valid, 3))
        else begin
            $error("retirement without an instruction three cycles earlier");
            fail_cnt++;
        end

    a_x0_nowrite: assert property (@(posedge aclk) disable iff (!aresetn)
        (retire_valid && (retire_rd == '0)) |-> !retire_wr)
        else begin
            $error("retirement to x0 with write enable");
            fail_cnt++;
        end

endmodule

bind rv_exec_top rv_exec_checker chk_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .srst         (srst),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .retire_wr    (retire_wr),
    .retire_rd    (retire_rd)
);

// ==== tb/rv_exec_tb.sv ====
////////////////////
// rv exec testbench
// random and dependent ALU streams checked against a register model
////////////////////

`timescale 1ns/100ps

module rv_exec_tb;

    localparam int xlen = 32;
    localparam int idle_limit = 50;

    logic                  aclk;
    logic                  aresetn;
    logic                  srst;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  host_wr;
    rv_isa_pkg::reg_addr_t host_addr;
    logic [xlen-1:0]       host_val;
    rv_isa_pkg::reg_addr_t dbg_addr;
    logic [xlen-1:0]       dbg_val;
    logic                  retire_valid;
    logic                  retire_wr;
    rv_isa_pkg::reg_addr_t retire_rd;
    logic [xlen-1:0]       retire_val;

    logic [xlen-1:0]       model [32];
    integer                seed = 82;
    rv_isa_pkg::reg_addr_t last_rd [2];

    rv_exec_top #(.xlen(xlen), .rv32e(0)) dut_i (
        .aclk(aclk), .aresetn(aresetn), .srst(srst),
        .instr_valid(instr_valid), .instr(instr),
        .host_wr(host_wr), .host_addr(host_addr), .host_val(host_val),
        .dbg_addr(dbg_addr), .dbg_val(dbg_val),
        .retire_valid(retire_valid), .retire_wr(retire_wr),
        .retire_rd(retire_rd), .retire_val(retire_val)
    );

    rv_exec_monitor #(.xlen(xlen)) mon_i (
        .aclk(aclk), .aresetn(aresetn),
        .retire_valid(retire_valid), .retire_wr(retire_wr),
        .retire_rd(retire_rd), .retire_val(retire_val), .dbg_val(dbg_val)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // expected result of one ALU operation
    function automatic logic [xlen-1:0] exec_ref(input rv_isa_pkg::alu_op_e op,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        case (op)
            rv_isa_pkg::alu_add:  return a + b;
            rv_isa_pkg::alu_sub:  return a - b;
            rv_isa_pkg::alu_and:  return a & b;
            rv_isa_pkg::alu_or:   return a | b;
            rv_isa_pkg::alu_xor:  return a ^ b;
            rv_isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            rv_isa_pkg::alu_sltu: return (a < b) ? 1 : 0;
            rv_isa_pkg::alu_sll:  return a << b[4:0];
            rv_isa_pkg::alu_srl:  return a >> b[4:0];
            default:              return $signed(a) >>> b[4:0];
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input rv_isa_pkg::alu_op_e op);
        case (op)
            rv_isa_pkg::alu_sll:  return 3'b001;
            rv_isa_pkg::alu_slt:  return 3'b010;
            rv_isa_pkg::alu_sltu: return 3'b011;
            rv_isa_pkg::alu_xor:  return 3'b100;
            rv_isa_pkg::alu_srl,
            rv_isa_pkg::alu_sra:  return 3'b101;
            rv_isa_pkg::alu_or:   return 3'b110;
            rv_isa_pkg::alu_and:  return 3'b111;
            default:              return 3'b000;
        endcase
    endfunction

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    task automatic drive_instr(input logic [31:0] w);
        @(posedge aclk);
        instr_valid <= 1'b1;
        instr       <= w;
    endtask

    // model update in program order before the word is sent
    task automatic issue_op(input rv_isa_pkg::alu_op_e op, input logic use_imm,
                            input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::reg_addr_t rs1,
                            input rv_isa_pkg::reg_addr_t rs2, input logic [11:0] imm12);
        logic [xlen-1:0] b;
        logic [xlen-1:0] val;
        logic [6:0]      f7;
        logic [11:0]     imm;
        f7  = (op == rv_isa_pkg::alu_sub || op == rv_isa_pkg::alu_sra) ? 7'b0100000 : 7'b0;
        imm = (op == rv_isa_pkg::alu_sll || op == rv_isa_pkg::alu_srl ||
               op == rv_isa_pkg::alu_sra) ? {f7, imm12[4:0]} : imm12;
        b   = use_imm ? {{(xlen-12){imm[11]}}, imm} : model[rs2];
        val = exec_ref(op, model[rs1], b);
        mon_i.push(rd != 0, rd, val);
        if (rd != 0) begin
            model[rd] = val;
        end
        if (use_imm) begin
            drive_instr({imm, rs1, funct3_of(op), rd, rv_isa_pkg::op_imm});
        end else begin
            drive_instr({f7, rs2, rs1, funct3_of(op), rd, rv_isa_pkg::op_reg});
        end
    endtask

    // chain mode reads the rd of one of the two previous instructions
    task automatic rand_op(input logic chain);
        rv_isa_pkg::alu_op_e   op;
        logic                  use_imm;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        op      = rv_isa_pkg::alu_op_e'(rand_below(10));
        use_imm = (op != rv_isa_pkg::alu_sub) && rand_below(2);
        rd      = chain ? rv_isa_pkg::reg_addr_t'(1 + rand_below(31))
                        : rv_isa_pkg::reg_addr_t'(rand_below(32));
        rs1     = chain ? last_rd[rand_below(2)] : rv_isa_pkg::reg_addr_t'(rand_below(32));
        rs2     = chain ? last_rd[rand_below(2)] : rv_isa_pkg::reg_addr_t'(rand_below(32));
        issue_op(op, use_imm, rd, rs1, rs2, 12'(rand_below(4096)));
        last_rd[1] = last_rd[0];
        last_rd[0] = rd;
    endtask

    task automatic go_idle();
        @(posedge aclk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (mon_i.pending() != 0 && n < idle_limit) begin
            @(posedge aclk);
            n++;
        end
        if (mon_i.pending() != 0) begin
            $display("timeout: pipeline did not drain after %s", what);
            $display("TB FAILED");
            $finish;
        end else begin
            @(posedge aclk);
        end
    endtask

    task automatic host_write(input rv_isa_pkg::reg_addr_t addr, input logic [xlen-1:0] val);
        @(posedge aclk);
        host_wr   <= 1'b1;
        host_addr <= addr;
        host_val  <= val;
        if (addr != 0) begin
            model[addr] = val;
        end
    endtask

    task automatic debug_sweep();
        for (int a = 0; a < 32; a++) begin
            @(posedge aclk);
            dbg_addr <= rv_isa_pkg::reg_addr_t'(a);
            @(negedge aclk);
            mon_i.check_dbg(rv_isa_pkg::reg_addr_t'(a), model[a]);
        end
    endtask

    initial begin
        int          total;
        logic [31:0] bad_word;
        aresetn     = 1'b0;
        srst        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        host_wr     = 1'b0;
        host_addr   = '0;
        host_val    = '0;
        dbg_addr    = '0;
        last_rd     = '{default: 5'd1};
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        ////////////////////
        // preload and sweep including x0
        ////////////////////
        for (int i = 0; i < 32; i++) begin
            host_write(rv_isa_pkg::reg_addr_t'(i), $random(seed));
        end
        @(posedge aclk);
        host_wr <= 1'b0;
        debug_sweep();

        // random stream followed by dependent chains
        repeat (200) rand_op(1'b0);
        go_idle();
        wait_drain("random stream");
        debug_sweep();
        repeat (150) rand_op(1'b1);
        go_idle();
        wait_drain("dependent chains");
        debug_sweep();

        // unknown opcodes and writes to x0
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                bad_word = {25'($random(seed)), 7'b1100011};
                mon_i.push(1'b0, bad_word[11:7], '0);
                drive_instr(bad_word);
            end else begin
                issue_op(rv_isa_pkg::alu_add, 1'b1, '0, 5'(rand_below(32)), '0, 12'h7ff);
            end
        end
        go_idle();
        wait_drain("illegal and x0 writes");
        debug_sweep();

        ////////////////////
        // srst with instructions in flight
        ////////////////////
        repeat (6) rand_op(1'b0);
        @(posedge aclk);
        instr_valid <= 1'b0;
        srst        <= 1'b1;
        @(posedge aclk);
        srst <= 1'b0;
        mon_i.flush();
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        debug_sweep();

        total = mon_i.retire_errs + mon_i.dbg_errs + dut_i.chk_i.fail_cnt + mon_i.pending();
        $display("errors: retire %0d, debug %0d, assertion %0d, left in queue %0d",
                 mon_i.retire_errs, mon_i.dbg_errs, dut_i.chk_i.fail_cnt, mon_i.pending());
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_exec.f ====
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_exec_top.sv
tb/rv_exec_monitor.sv
tb/rv_exec_checker.sv
tb/rv_exec_tb.sv

// ==== Makefile ====
# Verilator build for the rv_exec pipeline and its testbench

VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FLIST     ?= rv_exec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
